// File: Makefile
# Verilator build and run for the SDRAM command side testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_hpdmc
FILELIST  := hpdmc_lite.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_STR  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_STR)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hpdmc_lite.f
+incdir+verilog
+incdir+testbench
verilog/hpdmc_pkg.sv
verilog/bank_safety_if.sv
verilog/hpdmc_timers.sv
verilog/hpdmc_rowtrack.sv
verilog/hpdmc_datactl.sv
verilog/hpdmc_mgmt.sv
verilog/hpdmc_top.sv
testbench/tb_hpdmc.sv

// File: testbench/hpdmc_ref.svh
/*
 * Reference bank model and expected-command rules for the testbench.
 * The model follows the commands seen on the pins, one word per access.
 */
`ifndef HPDMC_REF_SVH
`define HPDMC_REF_SVH

`include "hpdmc_consts.svh"

logic                       model_open [4];
logic [`SDRAM_ROWDEPTH-1:0] model_row [4];

// Word address layout is row, bank, column from high to low
function automatic logic [1:0] bank_of(input logic [`SDRAM_WADDR_W-1:0] a);
	return a[`SDRAM_COLDEPTH +: 2];
endfunction

function automatic logic [`SDRAM_ROWDEPTH-1:0] row_of(input logic [`SDRAM_WADDR_W-1:0] a);
	return a[`SDRAM_COLDEPTH+2 +: `SDRAM_ROWDEPTH];
endfunction

function automatic logic [`SDRAM_COLDEPTH-1:0] col_of(input logic [`SDRAM_WADDR_W-1:0] a);
	return a[`SDRAM_COLDEPTH-1:0];
endfunction

// Standard SDR truth table on cs_n, ras_n, cas_n, we_n
function automatic sdram_cmd_e decode_cmd(input logic cs_n, input logic ras_n,
		input logic cas_n, input logic we_n, input logic a10);
	case ({cs_n, ras_n, cas_n, we_n})
		4'b0011: return ACT;
		4'b0101: return RD;
		4'b0100: return WR;
		4'b0010: return a10 ? PREALL : PRE;   // A10 selects all banks
		4'b0001: return REF;
		default: return NOP;
	endcase
endfunction

function automatic sdram_cmd_e expected_first_cmd(input logic [1:0] b,
		input logic [`SDRAM_ROWDEPTH-1:0] r, input logic w);
	if (model_open[b] && model_row[b] == r)
		return w ? WR : RD;
	else if (model_open[b])
		return PRE;   // Another row is open and must close first
	return ACT;
endfunction

function automatic void model_update(input sdram_cmd_e c, input logic [1:0] b,
		input logic [`SDRAM_ROWDEPTH-1:0] adr);
	case (c)
		ACT: begin
			model_open[b] = 1'b1;
			model_row[b]  = adr;
		end
		PRE: model_open[b] = 1'b0;
		PREALL: begin
			for (int i = 0; i < 4; i++)
				model_open[i] = 1'b0;
		end
		default: ;
	endcase
endfunction

// Longest REF to PREALL distance when a worst-case access is still in flight
function automatic int refresh_bound(input int refi, input int rp, input int rcd);
	return refi + 2 + (rp + 1) + (rcd + 1) + `RD2WR_GAP + `WR_RECOVERY + 4;
endfunction

`endif

// File: testbench/tb_hpdmc.sv
/*
 * Testbench for the SDRAM command side with random one-word requests on a few rows.
 * Commands are sampled at the falling edge and checked against a bank model.
 * No DQ traffic is modelled.
 */
`timescale 1ns/1ps
`default_nettype none
`include "hpdmc_consts.svh"

module tb_hpdmc import hpdmc_pkg::*; ();

	`include "hpdmc_ref.svh"

	localparam int NUM_REQ     = 150;
	localparam int ACK_TIMEOUT = 1000;

	logic                       sys_clk;
	logic                       sdram_rst;
	logic [`TIM_RP_W-1:0]       tim_rp;
	logic [`TIM_RCD_W-1:0]      tim_rcd;
	logic [`TIM_REFI_W-1:0]     tim_refi;
	logic [`TIM_RFC_W-1:0]      tim_rfc;
	logic                       stb;
	logic                       we;
	logic [`SDRAM_WADDR_W-1:0]  address;
	logic                       ack;
	logic                       sdram_cs_n;
	logic                       sdram_we_n;
	logic                       sdram_cas_n;
	logic                       sdram_ras_n;
	logic [`SDRAM_ROWDEPTH-1:0] sdram_adr;
	logic [1:0]                 sdram_ba;

	int   errors;
	int   cyc;
	int   num_cmds;
	int   num_hits;
	int   num_refresh;
	int   num_done;
	logic first_done;     // First command of the current request already seen
	logic after_rst;
	int   last_pre [4];
	int   last_act [4];
	int   last_rd_bank [4];
	int   last_wr_bank [4];
	int   last_rd;
	int   last_wr;
	int   last_preall;
	int   last_ref;

	hpdmc_top UUT (
		.sys_clk, .sdram_rst, .tim_rp, .tim_rcd, .tim_refi, .tim_rfc,
		.stb, .we, .address, .ack,
		.sdram_cs_n, .sdram_we_n, .sdram_cas_n, .sdram_ras_n, .sdram_adr, .sdram_ba
	);

	task automatic log_mismatch(input string sig, input int got, input int exp);
		errors++;
		$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, sig, got, exp);
	endtask

	task automatic raise_error(input string what);
		errors++;
		$display("ERROR t=%0t: %s", $time, what);
	endtask

	task automatic check_gap(input string what, input int gap, input int min_gap);
		assert (gap >= min_gap)
		else raise_error($sformatf("%s only %0d cycles apart, need %0d", what, gap, min_gap));
	endtask

	task automatic finish_run();
		$display("requests=%0d page_hits=%0d refreshes=%0d errors=%0d",
			num_done, num_hits, num_refresh, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// Compares at the falling edge where all pins have settled
	always @(negedge sys_clk) begin : monitor
		sdram_cmd_e c;
		sdram_cmd_e exp_cmd;
		logic [1:0] rb;
		c  = decode_cmd(sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_adr[10]);
		rb = bank_of(address);
		cyc++;
		if (sdram_rst || after_rst) begin
			assert (ack == 1'b0) else log_mismatch("ack", int'(ack), 0);
			assert (c == NOP) else log_mismatch("command", int'(c), int'(NOP));
			after_rst = sdram_rst;   // One more check in the first free cycle
		end else if (c != NOP) begin
			if (num_cmds == 0)
				assert (c == PREALL) else raise_error("first command after reset is not PREALL");
			if (num_cmds == 1)
				assert (c == REF) else raise_error("PREALL after reset not followed by REF");
			check_gap("REF to next command", cyc - last_ref, int'(tim_rfc) + 1);
			if (stb && !first_done && c inside {ACT, PRE, RD, WR}) begin
				exp_cmd = expected_first_cmd(rb, row_of(address), we);
				assert (c == exp_cmd)
				else log_mismatch("first command", int'(c), int'(exp_cmd));
				if (c inside {RD, WR})
					num_hits++;
				first_done = 1'b1;
			end
			if (stb && c inside {ACT, PRE})
				assert (sdram_ba == rb)
				else log_mismatch("sdram_ba on ACT or PRE", int'(sdram_ba), int'(rb));
			case (c)
				ACT: begin
					check_gap("PRE to ACT", cyc - last_pre[sdram_ba], int'(tim_rp) + 1);
					if (stb)
						assert (sdram_adr == row_of(address))
						else log_mismatch("sdram_adr on ACT", int'(sdram_adr),
							int'(row_of(address)));
					last_act[sdram_ba] = cyc;
				end
				RD: begin
					check_gap("ACT to RD", cyc - last_act[sdram_ba], int'(tim_rcd) + 1);
					check_gap("WR to RD", cyc - last_wr, `WR2RD_GAP + 1);
					last_rd = cyc;
					last_rd_bank[sdram_ba] = cyc;
				end
				WR: begin
					check_gap("ACT to WR", cyc - last_act[sdram_ba], int'(tim_rcd) + 1);
					check_gap("RD to WR", cyc - last_rd, `RD2WR_GAP + 1);
					last_wr = cyc;
					last_wr_bank[sdram_ba] = cyc;
				end
				PRE: begin
					check_gap("WR to PRE", cyc - last_wr_bank[sdram_ba], `WR_RECOVERY + 1);
					check_gap("RD to PRE", cyc - last_rd_bank[sdram_ba], `RD2PRE_GAP + 1);
					last_pre[sdram_ba] = cyc;
				end
				PREALL: begin
					for (int b = 0; b < 4; b++) begin
						check_gap("WR to PREALL", cyc - last_wr_bank[b], `WR_RECOVERY + 1);
						check_gap("RD to PREALL", cyc - last_rd_bank[b], `RD2PRE_GAP + 1);
					end
					if (num_refresh > 0)
						assert (cyc - last_ref <= refresh_bound(int'(tim_refi), int'(tim_rp),
							int'(tim_rcd)))
						else raise_error("refresh came later than the refresh interval allows");
					last_preall = cyc;
				end
				REF: begin
					check_gap("PREALL to REF", cyc - last_preall, int'(tim_rp) + 1);
					last_ref = cyc;
					num_refresh++;
				end
				default: ;
			endcase
			model_update(c, sdram_ba, sdram_adr);
			num_cmds++;
		end
		if (ack && !sdram_rst) begin
			exp_cmd = we ? WR : RD;
			assert (c == exp_cmd) else log_mismatch("command on ack", int'(c), int'(exp_cmd));
			assert (sdram_ba == rb) else log_mismatch("sdram_ba", int'(sdram_ba), int'(rb));
			assert (int'(sdram_adr) == int'(col_of(address)))
			else log_mismatch("sdram_adr column", int'(sdram_adr), int'(col_of(address)));
			first_done = 1'b0;
		end
	end

	initial begin : stimulus
		logic [`SDRAM_ROWDEPTH-1:0] rows [3];
		logic timed_out;
		int   wait_cnt;
		int   ri;
		rows[0] = 13'h0012;   // Only a few rows so that page hits are common
		rows[1] = 13'h0a31;
		rows[2] = 13'h1f07;
		timed_out = 1'b0;
		errors = 0;
		cyc = 0;
		num_cmds = 0;
		num_hits = 0;
		num_refresh = 0;
		num_done = 0;
		first_done = 1'b0;
		after_rst = 1'b0;
		last_rd = -1000;
		last_wr = -1000;
		last_preall = -1000;
		last_ref = -1000;
		for (int b = 0; b < 4; b++) begin
			last_pre[b] = -1000;
			last_act[b] = -1000;
			last_rd_bank[b] = -1000;
			last_wr_bank[b] = -1000;
			model_open[b] = 1'b0;
			model_row[b] = '0;
		end
		void'($urandom(32'h982a6eb6));
		sdram_rst = 1'b1;
		stb = 1'b0;
		we = 1'b0;
		address = '0;
		tim_rp = 3'd2;
		tim_rcd = 3'd2;
		tim_refi = 11'd300;
		tim_rfc = 4'd6;
		repeat (2) @(posedge sys_clk);
		#2 sdram_rst = 1'b0;
		for (int n = 0; n < NUM_REQ && !timed_out; n++) begin
			ri = $urandom % 3;
			stb = 1'b1;
			we = 1'($urandom);
			address = {1'b0, rows[ri], 2'($urandom), 9'($urandom)};
			wait_cnt = 0;
			@(negedge sys_clk);
			while (!ack && wait_cnt < ACK_TIMEOUT) begin
				@(negedge sys_clk);
				wait_cnt++;
			end
			if (ack) begin
				num_done++;
			end else begin
				raise_error("request was not acknowledged within 1000 cycles");
				timed_out = 1'b1;
			end
			@(posedge sys_clk);
			#2;
			if ($urandom % 4 == 0) begin
				stb = 1'b0;
				repeat (1 + $urandom % 3) @(posedge sys_clk);
				#2;
			end
		end
		stb = 1'b0;
		repeat (4) @(posedge sys_clk);
		assert (num_refresh >= 2) else raise_error("fewer than two refreshes were seen");
		finish_run();
	end

endmodule

`default_nettype wire

// File: verilog/bank_safety_if.sv
/*
 * Link between the command FSM and the data control.
 * The FSM reports each issued command and its bank.
 * The safety flags are combinational and high when the command is allowed.
 */
`timescale 1ns/1ps
`default_nettype none

interface bank_safety_if import hpdmc_pkg::*; ();

	sdram_cmd_e issued_cmd;     // Command on the pins this cycle
	bank_mask_t concerned_bank; // One-hot bank of that command

	logic       read_safe;
	logic       write_safe;
	bank_mask_t precharge_safe;

	modport mgmt (
		output issued_cmd,
		output concerned_bank,
		input  read_safe,
		input  write_safe,
		input  precharge_safe
	);

	modport datactl (
		input  issued_cmd,
		input  concerned_bank,
		output read_safe,
		output write_safe,
		output precharge_safe
	);

endinterface

`default_nettype wire

// File: verilog/hpdmc_consts.svh
/*
 * Geometry and fixed timing for a 16-bit SDR SDRAM with four banks.
 * Word address is row, bank, column from high to low.
 * The top word address bit lies above the 13-bit row field and is ignored.
 * Turnaround gaps are in controller clock cycles and assume one-word bursts.
 */
`ifndef HPDMC_CONSTS_SVH
`define HPDMC_CONSTS_SVH

// Byte address width of the whole device
`define SDRAM_DEPTH     26
`define SDRAM_COLDEPTH  9
// Row field left over after byte select, two bank bits and one spare bit
`define SDRAM_ROWDEPTH  (`SDRAM_DEPTH - 4 - `SDRAM_COLDEPTH)
`define SDRAM_WADDR_W   (`SDRAM_DEPTH - 1)

`define TIM_RP_W        3
`define TIM_RCD_W       3
`define TIM_REFI_W      11
`define TIM_RFC_W       4

`define CAS_LAT         2

`define RD2WR_GAP       (`CAS_LAT + 2)  // Read data must clear DQ before write data
`define WR2RD_GAP       2
`define WR_RECOVERY     3               // tWR plus the write data cycle
`define RD2PRE_GAP      1

`endif

// File: verilog/hpdmc_datactl.sv
/*
 * Read/write turnaround and precharge safety windows.
 * A RD or WR seen at a clock edge closes the matching windows for a fixed
 * number of cycles, set by the gap macros. Flags are high when safe.
 */
`timescale 1ns/1ps
`default_nettype none
`include "hpdmc_consts.svh"

module hpdmc_datactl import hpdmc_pkg::*; (
	input  wire               sys_clk,
	input  wire               sdram_rst,
	bank_safety_if.datactl    safety
);

	localparam int RD2WR_W  = $clog2(`RD2WR_GAP + 1);
	localparam int WR2RD_W  = $clog2(`WR2RD_GAP + 1);
	localparam int WREC_W   = $clog2(`WR_RECOVERY + 1);
	localparam int RD2PRE_W = $clog2(`RD2PRE_GAP + 1);

	logic [RD2WR_W-1:0]  rd2wr_cnt;
	logic [WR2RD_W-1:0]  wr2rd_cnt;
	logic [WREC_W-1:0]   wrrec_cnt [4];   // Write recovery per bank
	logic [RD2PRE_W-1:0] rd2pre_cnt [4];
	logic                is_rd;
	logic                is_wr;

	assign is_rd = (safety.issued_cmd == RD);
	assign is_wr = (safety.issued_cmd == WR);

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd2wr_cnt <= '0;
			wr2rd_cnt <= '0;
			for (int b = 0; b < 4; b++) begin
				wrrec_cnt[b]  <= '0;
				rd2pre_cnt[b] <= '0;
			end
		end else begin
			if (is_rd)
				rd2wr_cnt <= RD2WR_W'(`RD2WR_GAP);
			else if (rd2wr_cnt != '0)
				rd2wr_cnt <= rd2wr_cnt - 1'b1;
			if (is_wr)
				wr2rd_cnt <= WR2RD_W'(`WR2RD_GAP);
			else if (wr2rd_cnt != '0)
				wr2rd_cnt <= wr2rd_cnt - 1'b1;
			for (int b = 0; b < 4; b++) begin
				if (is_wr && safety.concerned_bank[b])
					wrrec_cnt[b] <= WREC_W'(`WR_RECOVERY);
				else if (wrrec_cnt[b] != '0)
					wrrec_cnt[b] <= wrrec_cnt[b] - 1'b1;
				if (is_rd && safety.concerned_bank[b])
					rd2pre_cnt[b] <= RD2PRE_W'(`RD2PRE_GAP);
				else if (rd2pre_cnt[b] != '0)
					rd2pre_cnt[b] <= rd2pre_cnt[b] - 1'b1;
			end
		end
	end

	assign safety.read_safe  = (wr2rd_cnt == '0);
	assign safety.write_safe = (rd2wr_cnt == '0);

	always_comb begin
		for (int b = 0; b < 4; b++)
			safety.precharge_safe[b] = (wrrec_cnt[b] == '0) && (rd2pre_cnt[b] == '0);
	end

	// The FSM must respect the turnaround windows this block reports
	rd_when_safe: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		is_rd |-> safety.read_safe);
	wr_when_safe: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		is_wr |-> safety.write_safe);

endmodule

`default_nettype wire

// File: verilog/hpdmc_mgmt.sv
/*
 * Command FSM for one request at a time.
 * The master holds stb, we and address until a one-cycle ack.
 * All pin outputs are combinational from the state and the inputs.
 * Mode register and power-up init must be done before reset is released.
 */
`timescale 1ns/1ps
`default_nettype none
`include "hpdmc_consts.svh"

module hpdmc_mgmt import hpdmc_pkg::*; (
	input  wire                       sys_clk,
	input  wire                       sdram_rst,
	input  wire                       stb,
	input  wire                       we,
	input  wire [`SDRAM_WADDR_W-1:0]  address,
	output logic                      ack,
	input  wire                       precharge_done,
	input  wire                       activate_done,
	input  wire                       must_refresh,
	input  wire                       autorefresh_done,
	output logic                      reload_rp,
	output logic                      reload_rcd,
	output logic                      reload_refi,
	output logic                      reload_rfc,
	input  wire                       bank_open,
	input  wire                       page_hit,
	output bank_mask_t                track_open,
	output bank_mask_t                track_close,
	output row_t                      row,
	output bank_t                     bank,
	bank_safety_if.mgmt               safety,
	output logic                      sdram_cs_n,
	output logic                      sdram_we_n,
	output logic                      sdram_cas_n,
	output logic                      sdram_ras_n,
	output row_t                      sdram_adr,
	output bank_t                     sdram_ba
);

	mgmt_state_e state;
	mgmt_state_e next_state;
	sdram_cmd_e  cmd;
	col_t        col;
	bank_mask_t  bank_onehot;
	logic        col_safe;
	logic        bank_pre_safe;

	assign col  = address[`SDRAM_COLDEPTH-1:0];
	assign bank = address[`SDRAM_COLDEPTH+1:`SDRAM_COLDEPTH];
	assign row  = address[`SDRAM_COLDEPTH+2 +: `SDRAM_ROWDEPTH];

	assign bank_onehot   = bank_mask_t'(1) << bank;
	assign col_safe      = we ? safety.write_safe : safety.read_safe;
	assign bank_pre_safe = &(safety.precharge_safe | ~bank_onehot);

	assign safety.issued_cmd     = cmd;
	assign safety.concerned_bank = bank_onehot;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state  = state;
		cmd         = NOP;
		ack         = 1'b0;
		reload_rp   = 1'b0;
		reload_rcd  = 1'b0;
		reload_refi = 1'b0;
		reload_rfc  = 1'b0;
		track_open  = '0;
		track_close = '0;
		case (state)
			IDLE: begin
				if (must_refresh) begin
					next_state = PRECHARGEALL;    // Refresh wins over a waiting request
				end else if (stb) begin
					if (page_hit) begin
						if (col_safe) begin
							cmd = we ? WR : RD;
							ack = 1'b1;
						end
					end else if (bank_open) begin
						if (bank_pre_safe) begin
							cmd         = PRE;    // Close the wrong row first
							track_close = bank_onehot;
							reload_rp   = 1'b1;
							next_state  = ACTIVATE;
						end
					end else begin
						cmd        = ACT;
						track_open = bank_onehot;
						reload_rcd = 1'b1;
						next_state = we ? WRITE : READ;
					end
				end
			end
			ACTIVATE: begin
				if (precharge_done) begin
					cmd        = ACT;
					track_open = bank_onehot;
					reload_rcd = 1'b1;
					next_state = we ? WRITE : READ;
				end
			end
			READ, WRITE: begin
				if (activate_done && col_safe) begin
					cmd        = (state == WRITE) ? WR : RD;
					ack        = 1'b1;
					next_state = IDLE;
				end
			end
			PRECHARGEALL: begin
				if (&safety.precharge_safe) begin
					cmd         = PREALL;
					track_close = '1;
					reload_rp   = 1'b1;
					next_state  = AUTOREFRESH;
				end
			end
			AUTOREFRESH: begin
				if (precharge_done) begin
					cmd         = REF;
					reload_refi = 1'b1;
					reload_rfc  = 1'b1;
					next_state  = AUTOREFRESH_WAIT;
				end
			end
			AUTOREFRESH_WAIT: begin
				if (autorefresh_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	// Pin encoding as cs_n, ras_n, cas_n, we_n
	always_comb begin
		case (cmd)
			ACT:     {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b0011;
			RD:      {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b0101;
			WR:      {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b0100;
			PRE,
			PREALL:  {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b0010;
			REF:     {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b0001;
			default: {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = 4'b1111;
		endcase
	end

	// A10 high selects all banks on PREALL
	always_comb begin
		case (cmd)
			ACT:     sdram_adr = row;
			RD, WR:  sdram_adr = row_t'(col);
			PREALL:  sdram_adr = row_t'(1) << 10;
			default: sdram_adr = '0;
		endcase
	end

	assign sdram_ba = bank;

	ack_on_column_cmd: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		ack |-> (cmd inside {RD, WR}));
	state_legal: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		state inside {IDLE, ACTIVATE, READ, WRITE, PRECHARGEALL, AUTOREFRESH,
			AUTOREFRESH_WAIT});

endmodule

`default_nettype wire

// File: verilog/hpdmc_pkg.sv
/*
 * Types shared by the SDRAM command side.
 * Address field widths follow the macros in the consts header.
 */
`include "hpdmc_consts.svh"
`default_nettype none

package hpdmc_pkg;

	// Command placed on the SDRAM pins in the current cycle
	typedef enum logic [2:0] {
		NOP,
		ACT,
		RD,
		WR,
		PRE,
		PREALL,
		REF
	} sdram_cmd_e;

	typedef enum logic [2:0] {
		IDLE,
		ACTIVATE,
		READ,
		WRITE,
		PRECHARGEALL,
		AUTOREFRESH,
		AUTOREFRESH_WAIT
	} mgmt_state_e;

	typedef logic [`SDRAM_ROWDEPTH-1:0] row_t;
	typedef logic [`SDRAM_COLDEPTH-1:0] col_t;
	typedef logic [1:0] bank_t;
	typedef logic [3:0] bank_mask_t;   // One bit per bank

endpackage

`default_nettype wire

// File: verilog/hpdmc_rowtrack.sv
/*
 * Open-row table for four banks.
 * A bank opened by track_open stores the current row in the same cycle.
 * Row contents are only meaningful while the bank's open bit is set.
 */
`timescale 1ns/1ps
`default_nettype none

module hpdmc_rowtrack import hpdmc_pkg::*; (
	input  wire        sys_clk,
	input  wire        sdram_rst,
	input  bank_mask_t track_open,
	input  bank_mask_t track_close,
	input  row_t       row,
	input  bank_t      bank,
	output logic       bank_open,
	output logic       page_hit
);

	bank_mask_t has_openrow;
	row_t       openrows [4];

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			has_openrow <= '0;
		else
			has_openrow <= (has_openrow | track_open) & ~track_close;
	end

	// Row latched on ACT for each bank
	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (track_open[b])
				openrows[b] <= row;
		end
	end

	assign bank_open = has_openrow[bank];
	assign page_hit  = bank_open && (openrows[bank] == row);

	// Opening and closing the same bank at once would leave the table ambiguous
	no_open_close_clash: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		(track_open & track_close) == '0);

endmodule

`default_nettype wire

// File: verilog/hpdmc_timers.sv
/*
 * Down-counters for tRP, tRCD, tREFI and tRFC.
 * A reload strobe in the command cycle makes done go high tim+1 cycles later.
 * Only the refresh counter is reset, to zero, so a refresh comes first.
 * The timing inputs must be stable while the controller runs.
 */
`timescale 1ns/1ps
`default_nettype none
`include "hpdmc_consts.svh"

module hpdmc_timers (
	input  wire                    sys_clk,
	input  wire                    sdram_rst,
	input  wire [`TIM_RP_W-1:0]    tim_rp,
	input  wire [`TIM_RCD_W-1:0]   tim_rcd,
	input  wire [`TIM_REFI_W-1:0]  tim_refi,
	input  wire [`TIM_RFC_W-1:0]   tim_rfc,
	input  wire                    reload_rp,
	input  wire                    reload_rcd,
	input  wire                    reload_refi,
	input  wire                    reload_rfc,
	output logic                   precharge_done,
	output logic                   activate_done,
	output logic                   must_refresh,
	output logic                   autorefresh_done
);

	logic [`TIM_RP_W-1:0]   rp_cnt;
	logic [`TIM_RCD_W-1:0]  rcd_cnt;
	logic [`TIM_REFI_W-1:0] refi_cnt;
	logic [`TIM_RFC_W-1:0]  rfc_cnt;

	assign precharge_done   = (rp_cnt == '0);
	assign activate_done    = (rcd_cnt == '0);
	assign must_refresh     = (refi_cnt == '0);
	assign autorefresh_done = (rfc_cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (reload_rp)
			rp_cnt <= tim_rp;
		else if (!precharge_done)
			rp_cnt <= rp_cnt - 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (reload_rcd)
			rcd_cnt <= tim_rcd;
		else if (!activate_done)
			rcd_cnt <= rcd_cnt - 1'b1;
	end

	// Holds at zero until the next REF reloads it
	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			refi_cnt <= '0;
		else if (reload_refi)
			refi_cnt <= tim_refi;
		else if (!must_refresh)
			refi_cnt <= refi_cnt - 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (reload_rfc)
			rfc_cnt <= tim_rfc;
		else if (!autorefresh_done)
			rfc_cnt <= rfc_cnt - 1'b1;
	end

	// An ACT must never overlap a precharge still in progress
	rcd_after_rp: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		reload_rcd |-> precharge_done);

endmodule

`default_nettype wire

// File: verilog/hpdmc_top.sv
/*
 * Command side of a four-bank 16-bit SDR SDRAM controller.
 * No DQ path, no init sequence and single-word bursts only.
 * Timing inputs are in cycles and must be stable while running.
 */
`timescale 1ns/1ps
`default_nettype none
`include "hpdmc_consts.svh"

module hpdmc_top import hpdmc_pkg::*; (
	input  wire                          sys_clk,
	input  wire                          sdram_rst,
	input  wire [`TIM_RP_W-1:0]          tim_rp,
	input  wire [`TIM_RCD_W-1:0]         tim_rcd,
	input  wire [`TIM_REFI_W-1:0]        tim_refi,
	input  wire [`TIM_RFC_W-1:0]         tim_rfc,
	input  wire                          stb,
	input  wire                          we,
	input  wire [`SDRAM_WADDR_W-1:0]     address,
	output logic                         ack,
	output logic                         sdram_cs_n,
	output logic                         sdram_we_n,
	output logic                         sdram_cas_n,
	output logic                         sdram_ras_n,
	output logic [`SDRAM_ROWDEPTH-1:0]   sdram_adr,
	output logic [1:0]                   sdram_ba
);

	logic       reload_rp;
	logic       reload_rcd;
	logic       reload_refi;
	logic       reload_rfc;
	logic       precharge_done;
	logic       activate_done;
	logic       must_refresh;
	logic       autorefresh_done;
	logic       bank_open;
	logic       page_hit;
	bank_mask_t track_open;
	bank_mask_t track_close;
	row_t       row;
	bank_t      bank;

	bank_safety_if safety ();

	hpdmc_mgmt mgmt (
		.sys_clk, .sdram_rst, .stb, .we, .address, .ack,
		.precharge_done, .activate_done, .must_refresh, .autorefresh_done,
		.reload_rp, .reload_rcd, .reload_refi, .reload_rfc,
		.bank_open, .page_hit, .track_open, .track_close, .row, .bank,
		.safety(safety.mgmt),
		.sdram_cs_n, .sdram_we_n, .sdram_cas_n, .sdram_ras_n, .sdram_adr, .sdram_ba
	);

	hpdmc_timers timers (
		.sys_clk, .sdram_rst, .tim_rp, .tim_rcd, .tim_refi, .tim_rfc,
		.reload_rp, .reload_rcd, .reload_refi, .reload_rfc,
		.precharge_done, .activate_done, .must_refresh, .autorefresh_done
	);

	hpdmc_rowtrack rowtrack (
		.sys_clk, .sdram_rst, .track_open, .track_close, .row, .bank,
		.bank_open, .page_hit
	);

	hpdmc_datactl datactl (
		.sys_clk, .sdram_rst,
		.safety(safety.datactl)
	);

endmodule

`default_nettype wire
